// ==== build.f ====
vram_pkg.sv
vram_arbiter.sv
tile_fetch_addr.sv
vram_addr_mux.sv
vram_ram.sv
vram_read_return.sv
vram_subsystem.sv
tb_vram_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the vram testbench with verilator
set -e
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_vram_subsystem \
	-f build.f \
	-o tb_vram_subsystem

./obj_dir/tb_vram_subsystem | tee "$LOG"

if grep -q "^>>> PASS$" "$LOG"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== tb_vram_subsystem.sv ====
`timescale 1ns/1ns

module tb_vram_subsystem;

	localparam int N_FILL = vram_pkg::VRAM_WORDS;
	localparam int N_RAND = 256;
	localparam int TOTAL_CYCLES = N_FILL + 7 * N_RAND + 20;
	localparam int WATCHDOG_NS = (TOTAL_CYCLES + 200) * 40;

	typedef struct packed {
		logic                         valid;
		logic                         care;
		logic [vram_pkg::VRAM_DW-1:0] data;
		int                           due;
	} exp_t;

	logic clk = 1'b0;
	logic arst_n;
	logic draw_mode;
	logic cpu_req;
	logic cpu_we;
	logic [15:0] cpu_addr;
	logic [vram_pkg::VRAM_DW-1:0] cpu_wdata;
	logic dma_req;
	logic [15:0] dma_addr;
	logic fetch_req;
	vram_pkg::fetch_kind_e fetch_kind;
	logic map_sel;
	logic tile_sel;
	logic [4:0] tile_row;
	logic [4:0] tile_col;
	logic [7:0] tile_index;
	logic [2:0] fine_y;
	logic [vram_pkg::VRAM_DW-1:0] cpu_rdata;
	logic cpu_rvalid;
	logic [vram_pkg::VRAM_DW-1:0] dma_rdata;
	logic dma_rvalid;
	logic [vram_pkg::VRAM_DW-1:0] fetch_data;
	logic fetch_valid;

	logic [vram_pkg::VRAM_DW-1:0] mirror [vram_pkg::VRAM_WORDS];
	exp_t cpu_q[$];
	exp_t dma_q[$];
	exp_t fetch_q[$];
	int cycle = 0;
	int checks = 0;
	int errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	int test_no = 0;

	vram_subsystem DUT (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [vram_pkg::VRAM_DW-1:0] fill_byte(input logic [12:0] a);
		return 8'(int'(a[7:0]) + int'(a[12:8]) * 29) ^ 8'h3c;
	endfunction

	function automatic logic [vram_pkg::VRAM_AW-1:0] ref_fetch_addr(
			input vram_pkg::fetch_kind_e kind, input logic m_sel, input logic t_sel,
			input logic [4:0] row, input logic [4:0] col, input logic [7:0] idx,
			input logic [2:0] fy);
		int a;
		if (kind == vram_pkg::FETCH_MAP) begin
			a = (m_sel ? 32'h1c00 : 32'h1800) + int'(row) * 32 + int'(col); // 0x9800 / 0x9c00
		end else if (t_sel) begin
			a = int'(idx) * 16; // 0x8000 block, unsigned index
		end else begin
			a = 4096 + int'($signed(idx)) * 16; // 0x9000 base, signed index
		end
		if (kind != vram_pkg::FETCH_MAP) begin
			a = a + int'(fy) * 2 + ((kind == vram_pkg::FETCH_DATA_HI) ? 1 : 0);
		end
		return 13'(a);
	endfunction

	function automatic exp_t expect_return(input vram_pkg::owner_e who, input logic draw,
			input logic c_req, input logic c_we, input logic [15:0] c_addr,
			input logic d_req, input logic [15:0] d_addr,
			input logic f_req, input logic [vram_pkg::VRAM_AW-1:0] f_addr);
		exp_t e;
		logic cpu_in;
		logic dma_in;
		cpu_in = c_req && (c_addr[15:13] == vram_pkg::VRAM_WINDOW);
		dma_in = d_req && (d_addr[15:13] == vram_pkg::VRAM_WINDOW);
		e = '0;
		e.care = 1'b1;
		e.data = vram_pkg::OPEN_BUS; // refused unless the rule below grants
		case (who)
			vram_pkg::OWN_CPU: begin
				e.valid = cpu_in;
				if (!draw && !dma_in) begin
					e.care = !c_we;
					e.data = mirror[c_addr[12:0]];
				end
			end
			vram_pkg::OWN_DMA: begin
				e.valid = dma_in;
				if (!draw) e.data = mirror[d_addr[12:0]];
			end
			default: begin
				e.valid = f_req;
				if (draw) e.data = mirror[f_addr];
			end
		endcase
		return e;
	endfunction

	task automatic compare_data(input string sig, input logic [vram_pkg::VRAM_DW-1:0] got,
			input logic [vram_pkg::VRAM_DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h at %0t", sig, got, exp, $time);
		end
	endtask

	task automatic compare_valid(input string sig, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h at %0t", sig, got, exp, $time);
		end
	endtask

	task automatic check_return(input string vname, input string dname, input logic valid,
			input logic [vram_pkg::VRAM_DW-1:0] data, input exp_t head, output logic pop);
		pop = (head.due == cycle);
		if (valid || pop) compare_valid(vname, valid, pop);
		if (valid && pop && head.care) compare_data(dname, data, head.data);
	endtask

	always @(negedge clk) begin : compare_returns
		exp_t head;
		logic pop;
		if (arst_n) begin
			head = '0;
			if (cpu_q.size() != 0) head = cpu_q[0];
			check_return("cpu_rvalid", "cpu_rdata", cpu_rvalid, cpu_rdata, head, pop);
			if (pop) void'(cpu_q.pop_front());
			head = '0;
			if (dma_q.size() != 0) head = dma_q[0];
			check_return("dma_rvalid", "dma_rdata", dma_rvalid, dma_rdata, head, pop);
			if (pop) void'(dma_q.pop_front());
			head = '0;
			if (fetch_q.size() != 0) head = fetch_q[0];
			check_return("fetch_valid", "fetch_data", fetch_valid, fetch_data, head, pop);
			if (pop) void'(fetch_q.pop_front());
		end
	end

	task automatic push_expected(input vram_pkg::owner_e who,
			input logic [vram_pkg::VRAM_AW-1:0] fa);
		exp_t e;
		e = expect_return(who, draw_mode, cpu_req, cpu_we, cpu_addr, dma_req, dma_addr,
			fetch_req, fa);
		e.due = cycle + 1; // returns one cycle after the sampling edge
		if (e.valid) begin
			case (who)
				vram_pkg::OWN_CPU: cpu_q.push_back(e);
				vram_pkg::OWN_DMA: dma_q.push_back(e);
				default: fetch_q.push_back(e);
			endcase
		end
	endtask

	task automatic step();
		logic [vram_pkg::VRAM_AW-1:0] fa;
		fa = ref_fetch_addr(fetch_kind, map_sel, tile_sel, tile_row, tile_col, tile_index,
			fine_y);
		push_expected(vram_pkg::OWN_CPU, fa);
		push_expected(vram_pkg::OWN_DMA, fa);
		push_expected(vram_pkg::OWN_FETCH, fa);
		if (cpu_req && cpu_we && !draw_mode && cpu_addr[15:13] == vram_pkg::VRAM_WINDOW &&
				!(dma_req && dma_addr[15:13] == vram_pkg::VRAM_WINDOW)) begin
			mirror[cpu_addr[12:0]] = cpu_wdata;
		end
		@(posedge clk);
		#5;
		cpu_req = 1'b0;
		dma_req = 1'b0;
		fetch_req = 1'b0;
	endtask

	task automatic cpu_access(input logic we, input logic [15:0] addr,
			input logic [vram_pkg::VRAM_DW-1:0] wdata);
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
	endtask

	task automatic finish_test(input string name);
		repeat (2) begin
			@(posedge clk);
			#5;
		end
		if (cpu_q.size() + dma_q.size() + fetch_q.size() != 0) begin
			errors++;
			$display("%s: some expected returns never arrived", name);
		end
		test_no++;
		$display("test %0d %s: %0d checks, %0d errors", test_no, name,
			checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	initial begin
		logic [12:0] addrs [$];
		logic [12:0] a;
		logic [15:0] oa;
		int i;
		void'($urandom(32'hcaff2517));
		arst_n = 1'b0;
		draw_mode = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		dma_req = 1'b0;
		dma_addr = '0;
		fetch_req = 1'b0;
		fetch_kind = vram_pkg::FETCH_MAP;
		map_sel = 1'b0;
		tile_sel = 1'b0;
		tile_row = '0;
		tile_col = '0;
		tile_index = '0;
		fine_y = '0;
		repeat (2) @(posedge clk);
		#5;
		arst_n = 1'b1;

		for (i = 0; i < N_FILL; i++) begin // whole vram known before any read
			cpu_access(1'b1, {vram_pkg::VRAM_WINDOW, 13'(i)}, fill_byte(13'(i)));
			step();
		end
		for (i = 0; i < N_RAND; i++) begin
			if (i % 8 == 5) begin
				oa = 16'($urandom);
				if (oa[15:13] == vram_pkg::VRAM_WINDOW) oa[15] = 1'b0;
				cpu_access(1'($urandom), oa, 8'($urandom)); // outside window, no return
			end else begin
				a = 13'($urandom);
				addrs.push_back(a);
				cpu_access(1'b1, {vram_pkg::VRAM_WINDOW, a}, 8'($urandom));
			end
			step();
		end
		foreach (addrs[k]) begin
			cpu_access(1'b0, {vram_pkg::VRAM_WINDOW, addrs[k]}, 8'h00);
			step();
		end
		finish_test("cpu round trip");

		addrs.delete();
		draw_mode = 1'b1;
		for (i = 0; i < N_RAND / 2; i++) begin
			a = 13'($urandom);
			addrs.push_back(a);
			cpu_access(1'($urandom), {vram_pkg::VRAM_WINDOW, a}, 8'($urandom));
			step();
		end
		draw_mode = 1'b0;
		foreach (addrs[k]) begin
			cpu_access(1'b0, {vram_pkg::VRAM_WINDOW, addrs[k]}, 8'h00);
			step();
		end
		finish_test("draw-mode lockout");

		for (i = 0; i < N_RAND; i++) begin
			dma_req = 1'b1;
			if (i % 4 == 3) begin
				dma_addr = {3'b110, 13'($urandom)}; // source page outside vram
				cpu_access(1'($urandom), {vram_pkg::VRAM_WINDOW, 13'($urandom)}, 8'($urandom));
			end else begin
				dma_addr = {vram_pkg::VRAM_WINDOW, 13'($urandom)};
				if (i % 2 == 0) begin
					cpu_access(1'($urandom), {vram_pkg::VRAM_WINDOW, 13'($urandom)},
						8'($urandom));
				end
			end
			step();
		end
		finish_test("dma reads");

		draw_mode = 1'b1;
		for (i = 0; i < N_RAND; i++) begin
			fetch_req = 1'b1;
			if (1'($urandom)) fetch_kind = vram_pkg::FETCH_DATA_HI;
			else fetch_kind = vram_pkg::FETCH_DATA_LO;
			tile_sel = 1'(i);
			tile_index = 8'($urandom);
			fine_y = 3'($urandom);
			if (i % 5 == 2) begin
				dma_req = 1'b1; // refused in draw mode
				dma_addr = {vram_pkg::VRAM_WINDOW, 13'($urandom)};
			end
			step();
		end
		finish_test("tile-data fetches");

		for (i = 0; i < N_RAND; i++) begin
			fetch_req = 1'b1;
			fetch_kind = vram_pkg::FETCH_MAP;
			map_sel = 1'(i);
			tile_row = 5'($urandom);
			tile_col = 5'($urandom);
			step();
		end
		draw_mode = 1'b0;
		for (i = 0; i < N_RAND / 2; i++) begin
			fetch_req = 1'b1;
			fetch_kind = vram_pkg::fetch_kind_e'(2'($urandom % 3));
			step();
		end
		finish_test("map and refused fetches");

		$display("summary: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== tile_fetch_addr.sv ====
`timescale 1ns/1ns

module tile_fetch_addr (
	input  vram_pkg::fetch_kind_e          fetch_kind,
	input  logic                           map_sel,
	input  logic                           tile_sel,
	input  logic [4:0]                     tile_row,
	input  logic [4:0]                     tile_col,
	input  logic [7:0]                     tile_index,
	input  logic [2:0]                     fine_y,
	output logic [vram_pkg::VRAM_AW-1:0]   fetch_addr
);

	logic [vram_pkg::VRAM_AW-1:0] map_addr;
	logic [vram_pkg::VRAM_AW-1:0] data_addr;
	logic                         data_hi;
	logic                         plane;

	// 0x9800 or 0x9c00 map, 32x32 entries
	assign map_addr = {vram_pkg::MAP_AREA, map_sel, tile_row, tile_col};

	// bit 12 low selects the 0x8000 block
	// unsigned mode always lands there, signed mode only for index >= 0x80
	assign data_hi = ~(tile_sel | tile_index[7]);

	always_comb begin
		case (fetch_kind)
			vram_pkg::FETCH_DATA_HI: plane = 1'b1;
			default:                 plane = 1'b0; // low bitplane
		endcase
	end

	// 16 bytes per tile, two per row
	assign data_addr = {data_hi, tile_index, fine_y, plane};

	always_comb begin
		case (fetch_kind)
			vram_pkg::FETCH_MAP: begin
				fetch_addr = map_addr;
			end
			default: begin
				fetch_addr = data_addr;
			end
		endcase
	end

endmodule

// ==== vram_addr_mux.sv ====
`timescale 1ns/1ns

module vram_addr_mux (
	input  logic                           clk,
	input  logic                           arst_n,
	input  vram_pkg::owner_e               grant,
	input  logic                           grant_we,
	input  logic [vram_pkg::VRAM_AW-1:0]   cpu_addr,
	input  logic [vram_pkg::VRAM_DW-1:0]   cpu_wdata,
	input  logic [vram_pkg::VRAM_AW-1:0]   dma_addr,
	input  logic [vram_pkg::VRAM_AW-1:0]   fetch_addr,
	output logic [vram_pkg::VRAM_AW-1:0]   ram_addr,
	output logic                           ram_we,
	output logic [vram_pkg::VRAM_DW-1:0]   ram_wdata
);

	logic [vram_pkg::VRAM_AW-1:0] addr_q;
	logic [vram_pkg::VRAM_DW-1:0] wdata_q;

	// granted address, otherwise keep the bus where it was
	always_comb begin
		case (grant)
			vram_pkg::OWN_CPU:   ram_addr = cpu_addr;
			vram_pkg::OWN_DMA:   ram_addr = dma_addr;
			vram_pkg::OWN_FETCH: ram_addr = fetch_addr;
			default:             ram_addr = addr_q;
		endcase
	end

	assign ram_we    = grant_we;
	assign ram_wdata = grant_we ? cpu_wdata : wdata_q; // md only moves on a write

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			addr_q  <= '0;
			wdata_q <= '0;
		end else begin
			addr_q  <= ram_addr;
			wdata_q <= ram_wdata;
		end
	end

endmodule

// ==== vram_arbiter.sv ====
`timescale 1ns/1ns

module vram_arbiter (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             draw_mode,
	input  logic             cpu_req,
	input  logic             cpu_we,
	input  logic [2:0]       cpu_addr_hi,
	input  logic             dma_req,
	input  logic [2:0]       dma_addr_hi,
	input  logic             fetch_req,
	output vram_pkg::owner_e grant,
	output logic             grant_we,
	output logic             cpu_refused,
	output logic             dma_refused,
	output logic             fetch_refused
);

	logic cpu_hit;
	logic dma_hit;

	assign cpu_hit = cpu_req && (cpu_addr_hi == vram_pkg::VRAM_WINDOW);
	assign dma_hit = dma_req && (dma_addr_hi == vram_pkg::VRAM_WINDOW); // source page in vram

	always_comb begin
		grant         = vram_pkg::OWN_NONE;
		cpu_refused   = 1'b0;
		dma_refused   = 1'b0;
		fetch_refused = 1'b0;

		if (draw_mode) begin
			if (fetch_req) begin
				grant = vram_pkg::OWN_FETCH;
			end
			cpu_refused = cpu_hit; // locked out even in idle fetch slots
			dma_refused = dma_hit;
		end else begin
			fetch_refused = fetch_req; // fetcher only runs in pixel transfer
			if (dma_hit) begin
				grant       = vram_pkg::OWN_DMA;
				cpu_refused = cpu_hit;
			end else if (cpu_hit) begin
				grant = vram_pkg::OWN_CPU;
			end
		end
	end

	assign grant_we = (grant == vram_pkg::OWN_CPU) && cpu_we;

	// a requester is either served or refused, never both
	a_grant_or_refuse: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(cpu_refused && (grant == vram_pkg::OWN_CPU)) &&
		!(dma_refused && (grant == vram_pkg::OWN_DMA)) &&
		!(fetch_refused && (grant == vram_pkg::OWN_FETCH))
	);

	a_we_only_cpu: assert property (
		@(posedge clk) disable iff (!arst_n)
		grant_we |-> (grant == vram_pkg::OWN_CPU)
	);

	// ppu owns the bus for the whole draw mode
	a_draw_fetch_only: assert property (
		@(posedge clk) disable iff (!arst_n)
		draw_mode |-> (grant inside {vram_pkg::OWN_NONE, vram_pkg::OWN_FETCH})
	);

endmodule

// ==== vram_pkg.sv ====
package vram_pkg;

	// memory geometry
	localparam int VRAM_AW = 13;
	localparam int VRAM_DW = 8;
	localparam int VRAM_WORDS = 1 << VRAM_AW;

	// cpu a[15:13] for the 0x8000-0x9fff window
	localparam logic [2:0] VRAM_WINDOW = 3'b100;

	// floating bus level seen on a refused read
	localparam logic [VRAM_DW-1:0] OPEN_BUS = 8'hff;

	// ma[12:11] of both tile maps
	localparam logic [1:0] MAP_AREA = 2'b11;

	typedef enum logic [1:0] {
		OWN_NONE  = 2'd0,
		OWN_CPU   = 2'd1,
		OWN_DMA   = 2'd2,
		OWN_FETCH = 2'd3
	} owner_e;

	typedef enum logic [1:0] {
		FETCH_MAP     = 2'd0,
		FETCH_DATA_LO = 2'd1,
		FETCH_DATA_HI = 2'd2
	} fetch_kind_e;

endpackage

// ==== vram_ram.sv ====
`timescale 1ns/1ns

module vram_ram (
	input  logic                           clk,
	input  logic [vram_pkg::VRAM_AW-1:0]   addr,
	input  logic                           we,
	input  logic [vram_pkg::VRAM_DW-1:0]   wdata,
	output logic [vram_pkg::VRAM_DW-1:0]   rdata
);

	logic [vram_pkg::VRAM_DW-1:0] mem [vram_pkg::VRAM_WORDS];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr]; // old contents on a write cycle
	end

endmodule

// ==== vram_read_return.sv ====
`timescale 1ns/1ns

module vram_read_return (
	input  logic                           clk,
	input  logic                           arst_n,
	input  vram_pkg::owner_e               grant,
	input  logic                           cpu_refused,
	input  logic                           dma_refused,
	input  logic                           fetch_refused,
	input  logic [vram_pkg::VRAM_DW-1:0]   ram_rdata,
	output logic [vram_pkg::VRAM_DW-1:0]   cpu_rdata,
	output logic                           cpu_rvalid,
	output logic [vram_pkg::VRAM_DW-1:0]   dma_rdata,
	output logic                           dma_rvalid,
	output logic [vram_pkg::VRAM_DW-1:0]   fetch_data,
	output logic                           fetch_valid
);

	vram_pkg::owner_e owner_q;
	logic             cpu_ref_q;
	logic             dma_ref_q;
	logic             fetch_ref_q;

	// follows the ram read by one edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owner_q     <= vram_pkg::OWN_NONE;
			cpu_ref_q   <= 1'b0;
			dma_ref_q   <= 1'b0;
			fetch_ref_q <= 1'b0;
		end else begin
			owner_q     <= grant;
			cpu_ref_q   <= cpu_refused;
			dma_ref_q   <= dma_refused;
			fetch_ref_q <= fetch_refused;
		end
	end

	assign cpu_rvalid  = (owner_q == vram_pkg::OWN_CPU) || cpu_ref_q;
	assign dma_rvalid  = (owner_q == vram_pkg::OWN_DMA) || dma_ref_q;
	assign fetch_valid = (owner_q == vram_pkg::OWN_FETCH) || fetch_ref_q;

	assign cpu_rdata  = cpu_ref_q ? vram_pkg::OPEN_BUS : ram_rdata; // bus floats high
	assign dma_rdata  = dma_ref_q ? vram_pkg::OPEN_BUS : ram_rdata;
	assign fetch_data = fetch_ref_q ? vram_pkg::OPEN_BUS : ram_rdata;

	// single port, so only one real access can come back
	a_one_granted_return: assert property (
		@(posedge clk) disable iff (!arst_n)
		$onehot0({cpu_rvalid && !cpu_ref_q,
		          dma_rvalid && !dma_ref_q,
		          fetch_valid && !fetch_ref_q})
	);

endmodule

// ==== vram_subsystem.sv ====
`timescale 1ns/1ns

module vram_subsystem (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           draw_mode,
	input  logic                           cpu_req,
	input  logic                           cpu_we,
	input  logic [15:0]                    cpu_addr,
	input  logic [vram_pkg::VRAM_DW-1:0]   cpu_wdata,
	input  logic                           dma_req,
	input  logic [15:0]                    dma_addr,
	input  logic                           fetch_req,
	input  vram_pkg::fetch_kind_e          fetch_kind,
	input  logic                           map_sel,
	input  logic                           tile_sel,
	input  logic [4:0]                     tile_row,
	input  logic [4:0]                     tile_col,
	input  logic [7:0]                     tile_index,
	input  logic [2:0]                     fine_y,
	output logic [vram_pkg::VRAM_DW-1:0]   cpu_rdata,
	output logic                           cpu_rvalid,
	output logic [vram_pkg::VRAM_DW-1:0]   dma_rdata,
	output logic                           dma_rvalid,
	output logic [vram_pkg::VRAM_DW-1:0]   fetch_data,
	output logic                           fetch_valid
);

	vram_pkg::owner_e             grant;
	logic                         grant_we;
	logic                         cpu_refused;
	logic                         dma_refused;
	logic                         fetch_refused;
	logic [vram_pkg::VRAM_AW-1:0] fetch_addr;
	logic [vram_pkg::VRAM_AW-1:0] ram_addr;
	logic                         ram_we;
	logic [vram_pkg::VRAM_DW-1:0] ram_wdata;
	logic [vram_pkg::VRAM_DW-1:0] ram_rdata;

	vram_arbiter u_arbiter (
		.clk           (clk),
		.arst_n        (arst_n),
		.draw_mode     (draw_mode),
		.cpu_req       (cpu_req),
		.cpu_we        (cpu_we),
		.cpu_addr_hi   (cpu_addr[15:13]),
		.dma_req       (dma_req),
		.dma_addr_hi   (dma_addr[15:13]),
		.fetch_req     (fetch_req),
		.grant         (grant),
		.grant_we      (grant_we),
		.cpu_refused   (cpu_refused),
		.dma_refused   (dma_refused),
		.fetch_refused (fetch_refused)
	);

	tile_fetch_addr u_fetch_addr (
		.fetch_kind (fetch_kind),
		.map_sel    (map_sel),
		.tile_sel   (tile_sel),
		.tile_row   (tile_row),
		.tile_col   (tile_col),
		.tile_index (tile_index),
		.fine_y     (fine_y),
		.fetch_addr (fetch_addr)
	);

	vram_addr_mux u_addr_mux (
		.clk        (clk),
		.arst_n     (arst_n),
		.grant      (grant),
		.grant_we   (grant_we),
		.cpu_addr   (cpu_addr[vram_pkg::VRAM_AW-1:0]),
		.cpu_wdata  (cpu_wdata),
		.dma_addr   (dma_addr[vram_pkg::VRAM_AW-1:0]),
		.fetch_addr (fetch_addr),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.ram_wdata  (ram_wdata)
	);

	vram_ram u_ram (
		.clk   (clk),
		.addr  (ram_addr),
		.we    (ram_we),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	vram_read_return u_read_return (
		.clk           (clk),
		.arst_n        (arst_n),
		.grant         (grant),
		.cpu_refused   (cpu_refused),
		.dma_refused   (dma_refused),
		.fetch_refused (fetch_refused),
		.ram_rdata     (ram_rdata),
		.cpu_rdata     (cpu_rdata),
		.cpu_rvalid    (cpu_rvalid),
		.dma_rdata     (dma_rdata),
		.dma_rvalid    (dma_rvalid),
		.fetch_data    (fetch_data),
		.fetch_valid   (fetch_valid)
	);

endmodule
